// ==== hw/typing_consts.svh ====
`ifndef TYPING_CONSTS_SVH
`define TYPING_CONSTS_SVH

// letter pool and playfield
`define SLOT_NUM 8
`define X_COLS 64
`define X_OFFSET 15 // pixel x is (column + offset) * 8
`define UPPER_BOUND 320 // top of the hit band
`define LOWER_BOUND 400 // bottom of the hit band
`define Y_MAX 472

// periods in clk cycles
`define SECOND_CYCLES 200 // 50_000_000 on the board
`define FRAME_CYCLES 4
`define SPAWN_CYCLES 60
`define FADE_CYCLES 40
`define GAME_SECONDS 60

// control keys
`define KEY_ENTER 8'h0d
`define KEY_T_UP 8'h54
`define KEY_T_LO 8'h74

// lfsr start values for letter, column and speed
`define LFSR_SEED0 32'h938ab4e1
`define LFSR_SEED1 32'h2a912bdf
`define LFSR_SEED2 32'hea57d2ac

`endif

// ==== hw/typing_pkg.sv ====
package typing_pkg;

	// key codes and letter codes
	typedef logic [7:0] ascii_t;

	// pixel coordinate of a letter
	typedef logic [11:0] coord_t;

	// fall step per frame, 1 to 4
	typedef logic [2:0] speed_t;

	// index into the letter pool
	typedef logic [2:0] slot_idx_t;

	// three bcd digits, hundreds in the top nibble
	typedef logic [11:0] bcd3_t;

	typedef enum logic [1:0] {
		ST_START  = 2'd0, // waiting for the first enter
		ST_RUN    = 2'd1,
		ST_STOP   = 2'd2, // paused by ctrl+t
		ST_FINISH = 2'd3  // time is up
	} game_state_e;

	typedef enum logic [1:0] {
		CLR_WHITE = 2'd0, // still falling
		CLR_RED   = 2'd1, // missed
		CLR_GREEN = 2'd2  // hit
	} char_color_e;

endpackage

// ==== hw/key_filter.sv ====
`include "typing_consts.svh"

module key_filter (
	input  logic               clk,
	input  logic               arst_n,
	input  typing_pkg::ascii_t ascii,
	input  logic               ctrl,
	output logic               key_press,
	output typing_pkg::ascii_t key_code,
	output logic               is_enter,
	output logic               is_pause,
	output logic               letter_press
);
	import typing_pkg::*;

	ascii_t last_code; // code seen one cycle earlier
	logic   ctrl_q;
	logic   is_t;

	// one press per new nonzero code
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_code <= '0;
			key_press <= 1'b0;
		end else begin
			last_code <= ascii;
			key_press <= (ascii != '0) && (ascii != last_code);
		end
	end

	always_ff @(posedge clk) begin
		key_code <= ascii; // aligned with key_press
		ctrl_q   <= ctrl;
	end

	assign is_t = (key_code == `KEY_T_UP) || (key_code == `KEY_T_LO);

	assign is_enter     = key_press && (key_code == `KEY_ENTER);
	assign is_pause     = key_press && ctrl_q && is_t;
	assign letter_press = key_press && !is_enter && !is_pause; // plain t is a letter

endmodule

// ==== hw/game_fsm.sv ====
`include "typing_consts.svh"

module game_fsm (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    is_enter,
	input  logic                    is_pause,
	input  typing_pkg::bcd3_t       time_bcd,
	output typing_pkg::game_state_e state,
	output logic                    frame_tick,
	output logic                    spawn_tick,
	output logic                    second_tick,
	output logic                    clear_all,
	output logic                    enter_finish
);
	import typing_pkg::*;

	localparam bcd3_t GAME_BCD = {4'(`GAME_SECONDS / 100), 4'((`GAME_SECONDS / 10) % 10),
		4'(`GAME_SECONDS % 10)};
	localparam int TICK_NUM = 3;
	localparam int CNT_W = $clog2(`SECOND_CYCLES); // second is the longest period
	localparam logic [CNT_W-1:0] TICK_LAST [TICK_NUM] = '{
		CNT_W'(`SECOND_CYCLES - 1),
		CNT_W'(`FRAME_CYCLES - 1),
		CNT_W'(`SPAWN_CYCLES - 1)
	};

	game_state_e         state_next;
	logic                time_done;
	logic [CNT_W-1:0]    tick_cnt [TICK_NUM];
	logic [TICK_NUM-1:0] tick_hit;

	assign time_done = (time_bcd == GAME_BCD);

	always_comb begin
		state_next = state;
		case (state)
			ST_RUN: begin
				if (time_done)
					state_next = ST_FINISH;
				else if (is_pause)
					state_next = ST_STOP;
			end
			default: begin
				if (is_enter)
					state_next = ST_RUN; // start, stop and finish all resume on enter
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= ST_START;
		else
			state <= state_next;
	end

	assign enter_finish = (state == ST_RUN) && time_done;
	assign clear_all    = (state == ST_FINISH) && is_enter;

	// period counters only advance in run
	always_comb begin
		for (int i = 0; i < TICK_NUM; i++)
			tick_hit[i] = (state == ST_RUN) && (tick_cnt[i] == TICK_LAST[i]);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < TICK_NUM; i++)
				tick_cnt[i] <= '0;
		end else if (state == ST_RUN) begin
			for (int i = 0; i < TICK_NUM; i++)
				tick_cnt[i] <= tick_hit[i] ? '0 : tick_cnt[i] + 1'b1;
		end
	end

	assign second_tick = tick_hit[0];
	assign frame_tick  = tick_hit[1];
	assign spawn_tick  = tick_hit[2];

	a_state_legal: assert property (@(posedge clk) disable iff (!arst_n)
		state inside {ST_START, ST_RUN, ST_STOP, ST_FINISH});

	// every state change needs a key press or the timeout behind it
	a_state_cause: assert property (@(posedge clk) disable iff (!arst_n)
		(state != $past(state)) |-> $past(is_enter || is_pause || time_done));

endmodule

// ==== hw/char_pool.sv ====
`include "typing_consts.svh"

module char_pool (
	input  logic                    clk,
	input  logic                    arst_n,
	input  typing_pkg::game_state_e state,
	input  logic                    frame_tick,
	input  logic                    spawn_tick,
	input  logic                    letter_press,
	input  typing_pkg::ascii_t      key_code,
	input  logic                    enter_finish,
	input  typing_pkg::slot_idx_t   slot_sel,
	output logic                    slot_valid,
	output typing_pkg::coord_t      slot_x,
	output typing_pkg::coord_t      slot_y,
	output typing_pkg::ascii_t      slot_text,
	output typing_pkg::char_color_e slot_color,
	output logic                    hit_pulse,
	output logic                    miss_pulse
);
	import typing_pkg::*;

	localparam int FADE_W = $clog2(`FADE_CYCLES);
	localparam int SCAN_W = $clog2(`SLOT_NUM + 1);
	localparam logic [SCAN_W-1:0] JUDGE_STEP = SCAN_W'(`SLOT_NUM); // one extra step per pass

	logic [`SLOT_NUM-1:0] valid;
	coord_t               pos_x [`SLOT_NUM];
	coord_t               pos_y [`SLOT_NUM];
	speed_t               speed [`SLOT_NUM];
	ascii_t               text [`SLOT_NUM];
	char_color_e          color [`SLOT_NUM];
	logic [FADE_W-1:0]    fade_cnt [`SLOT_NUM];

	logic [31:0] lfsr [3];
	ascii_t      rand_text;
	coord_t      rand_x;
	speed_t      rand_speed;
	logic        free_found;
	slot_idx_t   free_idx;

	logic              run;
	logic [SCAN_W-1:0] scan_step;
	slot_idx_t         scan_idx;
	logic              judge_step;
	logic              pend_valid; // press waiting for the next pass
	ascii_t            pend_code;
	logic              cur_valid; // press being judged in this pass
	ascii_t            cur_code;
	logic              best_found;
	slot_idx_t         best_idx;
	coord_t            best_y;
	logic              cand;
	logic              bound_hit;
	logic              in_band;
	logic              judge;

	function automatic logic [31:0] lfsr_next(input logic [31:0] r);
		return {r[22] ^ r[2] ^ r[1] ^ r[0], r[31:1]};
	endfunction

	function automatic coord_t fall_y(input coord_t y, input speed_t v);
		coord_t n;
		n = y + coord_t'(v);
		return (n > coord_t'(`Y_MAX)) ? coord_t'(`Y_MAX) : n;
	endfunction

	assign rand_text  = ascii_t'(8'h41 + lfsr[0][4:0] % 26);
	assign rand_x     = coord_t'((lfsr[1][7:0] % `X_COLS + `X_OFFSET) * 8);
	assign rand_speed = speed_t'(lfsr[2][1:0]) + speed_t'(1);

	// lowest free slot
	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		for (int i = `SLOT_NUM - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				free_found = 1'b1;
				free_idx   = slot_idx_t'(i);
			end
		end
	end

	assign run        = (state == ST_RUN);
	assign scan_idx   = slot_idx_t'(scan_step);
	assign judge_step = (scan_step == JUDGE_STEP);

	// matching white letter lower than the best so far
	assign cand = run && !judge_step && cur_valid && valid[scan_idx] &&
		(color[scan_idx] == CLR_WHITE) && (text[scan_idx] == cur_code) &&
		(pos_y[scan_idx] < coord_t'(`LOWER_BOUND)) &&
		(!best_found || (pos_y[scan_idx] > best_y));

	assign bound_hit = run && !judge_step && valid[scan_idx] &&
		(color[scan_idx] == CLR_WHITE) && (pos_y[scan_idx] >= coord_t'(`LOWER_BOUND));

	assign in_band = (pos_y[best_idx] >= coord_t'(`UPPER_BOUND)) &&
		(pos_y[best_idx] < coord_t'(`LOWER_BOUND));
	assign judge   = run && judge_step && cur_valid && best_found;

	assign hit_pulse  = judge && in_band;
	assign miss_pulse = bound_hit || (judge && !in_band); // scan and judge steps never overlap

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
			for (int i = 0; i < `SLOT_NUM; i++) begin
				color[i]    <= CLR_WHITE;
				fade_cnt[i] <= '0;
			end
			lfsr[0]    <= `LFSR_SEED0;
			lfsr[1]    <= `LFSR_SEED1;
			lfsr[2]    <= `LFSR_SEED2;
			scan_step  <= '0;
			pend_valid <= 1'b0;
			pend_code  <= '0;
			cur_valid  <= 1'b0;
			cur_code   <= '0;
			best_found <= 1'b0;
			best_idx   <= '0;
			best_y     <= '0;
		end else if (enter_finish) begin
			valid      <= '0; // pool empties at game over
			scan_step  <= '0;
			pend_valid <= 1'b0;
			cur_valid  <= 1'b0;
			best_found <= 1'b0;
		end else if (run) begin
			if (spawn_tick) begin
				for (int k = 0; k < 3; k++)
					lfsr[k] <= lfsr_next(lfsr[k]);
				if (free_found) begin
					valid[free_idx] <= 1'b1;
					color[free_idx] <= CLR_WHITE;
				end
			end
			for (int i = 0; i < `SLOT_NUM; i++) begin
				if (valid[i] && (color[i] != CLR_WHITE)) begin
					if (fade_cnt[i] == FADE_W'(`FADE_CYCLES - 1))
						valid[i] <= 1'b0;
					else
						fade_cnt[i] <= fade_cnt[i] + 1'b1;
				end
			end
			if (letter_press) begin
				pend_valid <= 1'b1; // a newer press replaces the older one
				pend_code  <= key_code;
			end
			if (bound_hit) begin
				color[scan_idx]    <= CLR_RED;
				fade_cnt[scan_idx] <= '0;
			end
			if (cand) begin
				best_found <= 1'b1;
				best_idx   <= scan_idx;
				best_y     <= pos_y[scan_idx];
			end
			if (judge_step) begin
				if (judge) begin
					color[best_idx]    <= in_band ? CLR_GREEN : CLR_RED;
					fade_cnt[best_idx] <= '0;
				end
				cur_valid  <= pend_valid || letter_press;
				cur_code   <= letter_press ? key_code : pend_code;
				pend_valid <= 1'b0;
				best_found <= 1'b0;
				scan_step  <= '0;
			end else begin
				scan_step <= scan_step + 1'b1;
			end
		end
	end

	// letter payload
	always_ff @(posedge clk) begin
		if (spawn_tick && free_found) begin
			pos_x[free_idx] <= rand_x;
			pos_y[free_idx] <= '0;
			speed[free_idx] <= rand_speed;
			text[free_idx]  <= rand_text;
		end
		if (frame_tick) begin
			for (int i = 0; i < `SLOT_NUM; i++) begin
				if (valid[i] && (color[i] == CLR_WHITE))
					pos_y[i] <= fall_y(pos_y[i], speed[i]);
			end
		end
	end

	assign slot_valid = valid[slot_sel];
	assign slot_x     = pos_x[slot_sel];
	assign slot_y     = pos_y[slot_sel];
	assign slot_text  = text[slot_sel];
	assign slot_color = color[slot_sel];

	a_one_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		!(hit_pulse && miss_pulse));

endmodule

// ==== hw/score_board.sv ====
module score_board (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              second_tick,
	input  logic              hit_pulse,
	input  logic              miss_pulse,
	input  logic              clear_all,
	output typing_pkg::bcd3_t time_bcd,
	output typing_pkg::bcd3_t hit_bcd,
	output typing_pkg::bcd3_t miss_bcd
);
	import typing_pkg::*;

	// add one with decimal carry, 999 wraps to 000
	function automatic bcd3_t bcd_inc(input bcd3_t v);
		bcd3_t r;
		logic  carry;
		r     = v;
		carry = 1'b1;
		for (int d = 0; d < 3; d++) begin
			if (carry) begin
				if (r[d*4 +: 4] == 4'd9) begin
					r[d*4 +: 4] = 4'd0;
				end else begin
					r[d*4 +: 4] = r[d*4 +: 4] + 4'd1;
					carry       = 1'b0;
				end
			end
		end
		return r;
	endfunction

	function automatic logic digits_ok(input bcd3_t v);
		return (v[3:0] <= 4'd9) && (v[7:4] <= 4'd9) && (v[11:8] <= 4'd9);
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			time_bcd <= '0;
			hit_bcd  <= '0;
			miss_bcd <= '0;
		end else if (clear_all) begin
			time_bcd <= '0; // new game
			hit_bcd  <= '0;
			miss_bcd <= '0;
		end else begin
			if (second_tick)
				time_bcd <= bcd_inc(time_bcd);
			if (hit_pulse)
				hit_bcd <= bcd_inc(hit_bcd);
			if (miss_pulse)
				miss_bcd <= bcd_inc(miss_bcd);
		end
	end

	a_bcd_digits: assert property (@(posedge clk) disable iff (!arst_n)
		digits_ok(time_bcd) && digits_ok(hit_bcd) && digits_ok(miss_bcd));

endmodule

// ==== hw/typing_game.sv ====
module typing_game (
	input  logic                    clk,
	input  logic                    arst_n,
	input  typing_pkg::ascii_t      ascii,
	input  logic                    ctrl,
	input  typing_pkg::slot_idx_t   slot_sel,
	output typing_pkg::game_state_e state,
	output typing_pkg::bcd3_t       time_bcd,
	output typing_pkg::bcd3_t       hit_bcd,
	output typing_pkg::bcd3_t       miss_bcd,
	output logic                    slot_valid,
	output typing_pkg::coord_t      slot_x,
	output typing_pkg::coord_t      slot_y,
	output typing_pkg::ascii_t      slot_text,
	output typing_pkg::char_color_e slot_color
);
	import typing_pkg::*;

	ascii_t key_code;
	logic   is_enter;
	logic   is_pause;
	logic   letter_press;
	logic   frame_tick;
	logic   spawn_tick;
	logic   second_tick;
	logic   clear_all;
	logic   enter_finish;
	logic   hit_pulse;
	logic   miss_pulse;

	key_filter key_filter_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.ascii        (ascii),
		.ctrl         (ctrl),
		.key_press    (), // only the decoded presses are needed here
		.key_code     (key_code),
		.is_enter     (is_enter),
		.is_pause     (is_pause),
		.letter_press (letter_press)
	);

	game_fsm game_fsm_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.is_enter     (is_enter),
		.is_pause     (is_pause),
		.time_bcd     (time_bcd),
		.state        (state),
		.frame_tick   (frame_tick),
		.spawn_tick   (spawn_tick),
		.second_tick  (second_tick),
		.clear_all    (clear_all),
		.enter_finish (enter_finish)
	);

	char_pool char_pool_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.state        (state),
		.frame_tick   (frame_tick),
		.spawn_tick   (spawn_tick),
		.letter_press (letter_press),
		.key_code     (key_code),
		.enter_finish (enter_finish),
		.slot_sel     (slot_sel),
		.slot_valid   (slot_valid),
		.slot_x       (slot_x),
		.slot_y       (slot_y),
		.slot_text    (slot_text),
		.slot_color   (slot_color),
		.hit_pulse    (hit_pulse),
		.miss_pulse   (miss_pulse)
	);

	score_board score_board_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.second_tick (second_tick),
		.hit_pulse   (hit_pulse),
		.miss_pulse  (miss_pulse),
		.clear_all   (clear_all),
		.time_bcd    (time_bcd),
		.hit_bcd     (hit_bcd),
		.miss_bcd    (miss_bcd)
	);

endmodule

// ==== bench/typing_game_checker.sv ====
module typing_game_checker (
	input logic                    clk,
	input logic                    arst_n,
	input typing_pkg::game_state_e state,
	input typing_pkg::bcd3_t       time_bcd,
	input typing_pkg::bcd3_t       hit_bcd,
	input typing_pkg::bcd3_t       miss_bcd
);
	timeunit 1ns;
	timeprecision 1ps;
	import typing_pkg::*;

	int          error_count = 0;
	int          test_count = 0;
	int          failed_count = 0;
	int          test_errors = 0;
	string       cur_name = "none";
	game_state_e prev_state;
	bcd3_t       prev_time;

	task automatic begin_test(input string name);
		cur_name    = name;
		test_errors = 0;
	endtask

	task automatic check_value(input string what, input int exp, input int act);
		if (exp != act) begin
			$display("[ERROR] %s %s: expected %03h, actual %03h", cur_name, what, exp, act);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("%s failed: %s", cur_name, msg);
		error_count++;
		test_errors++;
	endtask

	// a value below zero is not checked
	task automatic check_ports(input int exp_state, input int exp_time, input int exp_hit,
		input int exp_miss);
		if (exp_state >= 0)
			check_value("state", exp_state, int'(state));
		if (exp_time >= 0)
			check_value("time_bcd", exp_time, int'(time_bcd));
		if (exp_hit >= 0)
			check_value("hit_bcd", exp_hit, int'(hit_bcd));
		if (exp_miss >= 0)
			check_value("miss_bcd", exp_miss, int'(miss_bcd));
	endtask

	task automatic end_test();
		test_count++;
		if (test_errors == 0) begin
			$display("test %s passed", cur_name);
		end else begin
			$display("test %s failed with %0d errors", cur_name, test_errors);
			failed_count++;
		end
	endtask

	task automatic report_counts();
		$display("tests %0d, failed %0d, errors %0d", test_count, failed_count, error_count);
	endtask

	// time may only move after a run cycle, or clear on restart
	always @(negedge clk) begin
		if (arst_n && (time_bcd != prev_time) && (prev_state != ST_RUN) && (time_bcd != '0))
			report_problem("time_bcd changed outside the run state");
		prev_state = state;
		prev_time  = time_bcd;
	end

endmodule

// ==== bench/typing_game_tb.sv ====
`include "typing_consts.svh"

module typing_game_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import typing_pkg::*;

	localparam int HIT_MARGIN  = 24; // rows a letter can fall before its press is judged
	localparam int KEY_LIMIT   = 8;
	localparam int JUDGE_LIMIT = 2 * `SLOT_NUM + 6;
	localparam int POLL_LIMIT  = 8000;
	localparam int END_LIMIT   = 16000;

	logic        clk = 1'b0;
	logic        arst_n;
	ascii_t      ascii;
	logic        ctrl;
	slot_idx_t   slot_sel;
	game_state_e state;
	bcd3_t       time_bcd;
	bcd3_t       hit_bcd;
	bcd3_t       miss_bcd;
	logic        slot_valid;
	coord_t      slot_x;
	coord_t      slot_y;
	ascii_t      slot_text;
	char_color_e slot_color;

	logic        sv [`SLOT_NUM]; // slot snapshot
	coord_t      sx [`SLOT_NUM];
	coord_t      sy [`SLOT_NUM];
	ascii_t      st [`SLOT_NUM];
	char_color_e sc [`SLOT_NUM];

	int     fd;
	int     n_fields;
	string  line;
	string  name;
	string  cmd;
	string  f_arg;
	string  f_state;
	string  f_time;
	string  f_hit;
	string  f_miss;

	always #20 clk = ~clk;

	typing_game typing_game_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.ascii      (ascii),
		.ctrl       (ctrl),
		.slot_sel   (slot_sel),
		.state      (state),
		.time_bcd   (time_bcd),
		.hit_bcd    (hit_bcd),
		.miss_bcd   (miss_bcd),
		.slot_valid (slot_valid),
		.slot_x     (slot_x),
		.slot_y     (slot_y),
		.slot_text  (slot_text),
		.slot_color (slot_color)
	);

	typing_game_checker typing_game_checker (
		.clk      (clk),
		.arst_n   (arst_n),
		.state    (state),
		.time_bcd (time_bcd),
		.hit_bcd  (hit_bcd),
		.miss_bcd (miss_bcd)
	);

	function automatic int bcd_value(input bcd3_t v);
		return v[11:8] * 100 + v[7:4] * 10 + v[3:0];
	endfunction

	function automatic bcd3_t to_bcd(input int n);
		return {4'(n / 100 % 10), 4'(n / 10 % 10), 4'(n % 10)};
	endfunction

	function automatic int parse_field(input string s);
		int v;
		v = -1;
		if (s != "-")
			void'($sscanf(s, "%h", v));
		return v;
	endfunction

	function automatic logic is_white(input int i);
		return sv[i] && (sc[i] == CLR_WHITE);
	endfunction

	// nearest pixel x that a spawn column can give
	function automatic int snap_column(input int x);
		int col;
		col = x / 8;
		if (col < `X_OFFSET)
			col = `X_OFFSET;
		if (col > `X_COLS - 1 + `X_OFFSET)
			col = `X_COLS - 1 + `X_OFFSET;
		return col * 8;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic read_slots();
		for (int i = 0; i < `SLOT_NUM; i++) begin
			slot_sel = slot_idx_t'(i);
			#1;
			sv[i] = slot_valid;
			sx[i] = slot_x;
			sy[i] = slot_y;
			st[i] = slot_text;
			sc[i] = slot_color;
		end
		slot_sel = '0;
	endtask

	// bit 8 of code is the ctrl level
	task automatic press_key(input logic [8:0] code);
		next_cycle();
		ascii = code[7:0];
		ctrl  = code[8];
		next_cycle();
		next_cycle();
		ascii = '0;
		ctrl  = 1'b0;
	endtask

	// a letter whose lowest white copy sits in the band, or well above it
	task automatic pick_letter(input logic want_hit, output logic found, output ascii_t code);
		logic safe;
		int   top;
		safe  = 1'b1;
		found = 1'b0;
		code  = '0;
		for (int i = 0; i < `SLOT_NUM; i++)
			if (is_white(i) && (sy[i] > `LOWER_BOUND - HIT_MARGIN))
				safe = 1'b0; // a bound miss could land during the judgment
		for (int i = 0; i < `SLOT_NUM; i++) begin
			if (is_white(i)) begin
				top = 0;
				for (int j = 0; j < `SLOT_NUM; j++)
					if (is_white(j) && (st[j] == st[i]) && (sy[j] > top))
						top = sy[j];
				if (want_hit ? (top >= `UPPER_BOUND) : (top + HIT_MARGIN < `UPPER_BOUND)) begin
					found = safe;
					code  = st[i];
				end
			end
		end
	endtask

	task automatic wait_for_state(input int exp, input int limit, output logic ok);
		int n;
		n = 0;
		while ((int'(state) != exp) && (n < limit)) begin
			next_cycle();
			n++;
		end
		ok = (int'(state) == exp);
	endtask

	task automatic apply_key(input int code, input int es, input int et, input int eh,
		input int em);
		logic ok;
		press_key(9'(code));
		wait_for_state(es, KEY_LIMIT, ok);
		if (!ok)
			typing_game_checker.report_problem("state did not follow the key in time");
		next_cycle();
		typing_game_checker.check_ports(es, et, eh, em);
	endtask

	task automatic run_seconds(input int n, input int es);
		logic  running;
		bcd3_t t0;
		logic  v0 [`SLOT_NUM];
		coord_t y0 [`SLOT_NUM];
		running = (state == ST_RUN);
		t0      = time_bcd;
		read_slots();
		v0 = sv;
		y0 = sy;
		repeat (n * `SECOND_CYCLES) next_cycle();
		read_slots();
		if (running) begin
			typing_game_checker.check_value("time_bcd", to_bcd(bcd_value(t0) + n), time_bcd);
		end else begin
			typing_game_checker.check_value("time_bcd", t0, time_bcd);
			for (int i = 0; i < `SLOT_NUM; i++) begin
				typing_game_checker.check_value("slot_valid", v0[i], sv[i]);
				if (v0[i])
					typing_game_checker.check_value("slot_y", y0[i], sy[i]);
			end
		end
		for (int i = 0; i < `SLOT_NUM; i++)
			if (sv[i])
				typing_game_checker.check_value("slot_x", snap_column(sx[i]), sx[i]);
		typing_game_checker.check_ports(es, -1, -1, -1);
	endtask

	task automatic judge_letter(input logic want_hit, input int dh, input int dm);
		int     n;
		logic   found;
		ascii_t code;
		bcd3_t  h0;
		bcd3_t  m0;
		n     = 0;
		found = 1'b0;
		while (!found && (n < POLL_LIMIT)) begin
			next_cycle();
			read_slots();
			pick_letter(want_hit, found, code);
			n++;
		end
		if (!found) begin
			typing_game_checker.report_problem("no suitable letter appeared in time");
		end else begin
			h0 = hit_bcd;
			m0 = miss_bcd;
			press_key({1'b0, code});
			n = 0;
			while ((hit_bcd == h0) && (miss_bcd == m0) && (n < JUDGE_LIMIT)) begin
				next_cycle();
				n++;
			end
			if ((hit_bcd == h0) && (miss_bcd == m0))
				typing_game_checker.report_problem("the press was not judged in time");
			typing_game_checker.check_value("hit_bcd", to_bcd(bcd_value(h0) + dh), hit_bcd);
			typing_game_checker.check_value("miss_bcd", to_bcd(bcd_value(m0) + dm), miss_bcd);
		end
	endtask

	task automatic idle_to_bound(input int dh, input int dm);
		int    n;
		logic  seen;
		logic  crossed [`SLOT_NUM];
		bcd3_t h0;
		bcd3_t m0;
		n    = 0;
		seen = 1'b0;
		while (!seen && (n < POLL_LIMIT)) begin
			next_cycle();
			h0 = hit_bcd;
			m0 = miss_bcd;
			read_slots();
			for (int i = 0; i < `SLOT_NUM; i++) begin
				crossed[i] = is_white(i) && (sy[i] >= `LOWER_BOUND);
				if (crossed[i])
					seen = 1'b1;
			end
			n++;
		end
		if (!seen) begin
			typing_game_checker.report_problem("no letter reached the lower bound in time");
		end else begin
			n = 0;
			while ((miss_bcd == m0) && (n < JUDGE_LIMIT)) begin
				next_cycle();
				n++;
			end
			typing_game_checker.check_value("hit_bcd", to_bcd(bcd_value(h0) + dh), hit_bcd);
			typing_game_checker.check_value("miss_bcd", to_bcd(bcd_value(m0) + dm), miss_bcd);
			repeat (`SLOT_NUM + 2) next_cycle(); // one full scan pass
			read_slots();
			for (int i = 0; i < `SLOT_NUM; i++)
				if (crossed[i])
					typing_game_checker.check_value("slot_color", CLR_RED, sc[i]);
		end
	endtask

	task automatic await_finish(input int es, input int et);
		int    n;
		bcd3_t h_run;
		bcd3_t m_run;
		bcd3_t h0;
		bcd3_t m0;
		n     = 0;
		h_run = hit_bcd;
		m_run = miss_bcd;
		while ((int'(state) != es) && (n < END_LIMIT)) begin
			h_run = hit_bcd; // counts of the last cycle before the change
			m_run = miss_bcd;
			next_cycle();
			n++;
		end
		if (int'(state) != es)
			typing_game_checker.report_problem("state was not reached in time");
		next_cycle();
		h0 = hit_bcd;
		m0 = miss_bcd;
		typing_game_checker.check_value("hit_bcd", h_run, h0);
		if (bcd_value(m0) < bcd_value(m_run))
			typing_game_checker.report_problem("miss count fell when the game finished");
		repeat (2 * `SECOND_CYCLES) next_cycle(); // scores must hold in finish
		typing_game_checker.check_ports(es, et, h0, m0);
	endtask

	task automatic expect_ports(input int es, input int et, input int eh, input int em);
		typing_game_checker.check_ports(es, et, eh, em);
		if ((es == ST_START) || (es == ST_FINISH)) begin
			read_slots();
			for (int i = 0; i < `SLOT_NUM; i++)
				if (sv[i])
					typing_game_checker.report_problem("a slot is valid with an empty pool");
		end
	endtask

	initial begin
		arst_n   = 1'b0;
		ascii    = '0;
		ctrl     = 1'b0;
		slot_sel = '0;
		repeat (3) @(posedge clk);
		#2;
		arst_n = 1'b1;
		next_cycle();
		fd = $fopen("bench/typing_game_vectors.txt", "r");
		if (fd == 0) begin
			typing_game_checker.report_problem("vector file could not be opened");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				n_fields = $sscanf(line, "%s %s %s %s %s %s %s", name, cmd, f_arg, f_state,
					f_time, f_hit, f_miss);
				if ((line.len() < 2) || (line[0] == 8'h23) || (n_fields != 7))
					continue; // comment or blank line
				typing_game_checker.begin_test(name);
				case (cmd)
					"key": apply_key(parse_field(f_arg), parse_field(f_state),
						parse_field(f_time), parse_field(f_hit), parse_field(f_miss));
					"wait_seconds": run_seconds(parse_field(f_arg), parse_field(f_state));
					"hit_letter": judge_letter(1'b1, parse_field(f_hit), parse_field(f_miss));
					"miss_letter": judge_letter(1'b0, parse_field(f_hit), parse_field(f_miss));
					"idle": idle_to_bound(parse_field(f_hit), parse_field(f_miss));
					"wait_state": await_finish(parse_field(f_state), parse_field(f_time));
					"expect": expect_ports(parse_field(f_state), parse_field(f_time),
						parse_field(f_hit), parse_field(f_miss));
					default: typing_game_checker.report_problem("unknown command in vector file");
				endcase
				typing_game_checker.end_test();
			end
			$fclose(fd);
		end
		typing_game_checker.report_counts();
		if (typing_game_checker.error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== bench/typing_game_vectors.txt ====
# name cmd arg state time hit miss, all values in hex, - is not checked
# hit and miss are increments for hit_letter, miss_letter and idle, else absolute
reset_values     expect       -   0 000 000 000
letter_in_start  key          41  0 -   -   -
start_counts     expect       -   0 000 000 000
enter_starts     key          0d  1 -   -   -
run_time         wait_seconds 3   1 -   -   -
pause            key          154 2 -   -   -
pause_freeze     wait_seconds 3   2 -   -   -
resume           key          0d  1 -   -   -
more_time        wait_seconds 2   1 -   -   -
hit_in_band      hit_letter   -   1 -   1   0
early_press      miss_letter  -   1 -   0   1
second_hit       hit_letter   -   1 -   1   0
bound_miss       idle         -   1 -   0   1
run_to_end       wait_state   -   3 060 -   -
finish_pool      expect       -   3 060 -   -
restart          key          0d  1 000 000 000

// ==== typing_game.f ====
+incdir+hw
hw/typing_pkg.sv
hw/key_filter.sv
hw/game_fsm.sv
hw/char_pool.sv
hw/score_board.sv
hw/typing_game.sv
bench/typing_game_checker.sv
bench/typing_game_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = typing_game_tb
FILELIST  = typing_game.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)
